// File: source/dispatch_config.svh
`ifndef DISPATCH_CONFIG_SVH
`define DISPATCH_CONFIG_SVH

// ********************************************************************
// Front-end geometry.
// ********************************************************************

`define DISPATCH_LANES 4
`define ROB_DEPTH_LOG2 4
`define ROB_DEPTH (1 << `ROB_DEPTH_LOG2)
`define IQ_DEPTH 16

// Configuration register map.
`define CFG_ADDR_ENABLE 1'b0
`define CFG_ADDR_WATERMARK 1'b1

// Free queue entries required before a bundle is taken.
`define WATERMARK_RESET 8'd4

`endif

// File: source/dispatch_pkg.sv
`include "dispatch_config.svh"

package dispatch_pkg;

  // ********************************************************************
  // Decode result types.
  // ********************************************************************

  typedef enum logic [3:0] {
    ALU,
    ALU_IMM,
    LOAD,
    STORE,
    BRANCH,
    JAL,
    JALR,
    LUI,
    AUIPC,
    ILLEGAL
  } op_class_t;

  // One decoded instruction of 54 bits.
  typedef struct packed {
    logic [31:0] pc;
    op_class_t   op_class;
    logic [4:0]  dest_reg;
    logic        dest_reg_valid;
    logic [4:0]  src1_reg;
    logic        src1_valid;
    logic [4:0]  src2_reg;
    logic        src2_valid;
  } dec_inst_t;

  // The ROB slot travels with the instruction in each queue entry.
  typedef struct packed {
    logic [`ROB_DEPTH_LOG2-1:0] rob_slot;
    dec_inst_t                  dec_inst;
  } iq_entry_t;

endpackage

// File: source/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
  input  logic [31:0]            pc,
  input  logic [31:0]            inst_word,
  output dispatch_pkg::dec_inst_t di
);

  import dispatch_pkg::*;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  op_class_t op_class;
  logic      writes_rd;

  always_comb begin
    case (inst_word[6:0])
      OPC_OP:     op_class = ALU;
      OPC_OP_IMM: op_class = ALU_IMM;
      OPC_LOAD:   op_class = LOAD;
      OPC_STORE:  op_class = STORE;
      OPC_BRANCH: op_class = BRANCH;
      OPC_JAL:    op_class = JAL;
      OPC_JALR:   op_class = JALR;
      OPC_LUI:    op_class = LUI;
      OPC_AUIPC:  op_class = AUIPC;
      default:    op_class = ILLEGAL;
    endcase
  end

  // Stores, branches and illegal words produce no result.
  assign writes_rd = !(op_class inside {STORE, BRANCH, ILLEGAL});

  always_comb begin
    di.pc             = pc;
    di.op_class       = op_class;
    di.dest_reg       = inst_word[11:7];
    di.dest_reg_valid = writes_rd && (inst_word[11:7] != 5'd0);
    di.src1_reg       = inst_word[19:15];
    di.src1_valid     = op_class inside {ALU, ALU_IMM, LOAD, STORE, BRANCH, JALR};
    di.src2_reg       = inst_word[24:20];
    di.src2_valid     = op_class inside {ALU, STORE, BRANCH};
  end

endmodule

// File: source/decode_dispatch.sv
`timescale 1ns/1ps
`include "dispatch_config.svh"

module decode_dispatch (
  input  logic                       clock,
  input  logic                       rst_n,

  input  logic [31:0]                inst_word [`DISPATCH_LANES],
  input  logic [31:0]                inst_pc [`DISPATCH_LANES],
  input  logic                       inst_word_valid [`DISPATCH_LANES],

  input  logic                       dispatch_enable,
  input  logic [7:0]                 iq_watermark,
  input  logic [4:0]                 rob_free_count,
  input  logic [4:0]                 iq_free_count,
  input  logic [`ROB_DEPTH_LOG2-1:0] reserved_slots [`DISPATCH_LANES],
  output logic                       stall,

  output logic                       reserve,
  output logic [1:0]                 reserve_count,

  output logic                       ins_enable,
  output logic [1:0]                 new_count,
  output dispatch_pkg::iq_entry_t    new_elements [`DISPATCH_LANES]
);

  import dispatch_pkg::*;

  dec_inst_t  dec_inst [`DISPATCH_LANES];
  logic [2:0] valid_count;
  logic [7:0] iq_needed;
  logic       any_valid;
  logic       rob_short;
  logic       iq_short;

  for (genvar i = 0; i < `DISPATCH_LANES; i++) begin : g_dec
    inst_decoder u_dec (
      .pc        (inst_pc[i]),
      .inst_word (inst_word[i]),
      .di        (dec_inst[i])
    );
  end

  always_comb begin
    valid_count = 3'd0;
    for (int i = 0; i < `DISPATCH_LANES; i++) begin
      if (inst_word_valid[i]) begin
        valid_count = valid_count + 3'd1;
      end
    end
  end

  // ********************************************************************
  // Stall and request generation.
  // ********************************************************************

  assign any_valid = (valid_count != 3'd0);

  // The queue must keep at least the watermark free, or the whole bundle.
  assign iq_needed = (iq_watermark > {5'd0, valid_count}) ? iq_watermark : {5'd0, valid_count};
  assign rob_short = ({2'd0, valid_count} > rob_free_count);
  assign iq_short  = ({3'd0, iq_free_count} < iq_needed);

  assign stall      = !dispatch_enable || rob_short || iq_short;
  assign reserve    = !stall && any_valid;
  assign ins_enable = !stall && any_valid;

  // Counts are encoded as number of entries minus one.
  assign reserve_count = 2'(valid_count - 3'd1);
  assign new_count     = reserve_count;

  // ********************************************************************
  // Valid lanes move to the front, oldest first.
  // ********************************************************************

  always_comb begin : pack_lanes
    int pos;
    pos = 0;
    for (int k = 0; k < `DISPATCH_LANES; k++) begin
      new_elements[k].rob_slot = reserved_slots[k];
      new_elements[k].dec_inst = dec_inst[`DISPATCH_LANES-1];
    end
    for (int i = 0; i < `DISPATCH_LANES; i++) begin
      if (inst_word_valid[i]) begin
        new_elements[pos].dec_inst = dec_inst[i];
        pos = pos + 1;
      end
    end
  end

  // A queue write needs dispatch enabled, the watermark room and space for the encoded count.
  a_ins_no_stall: assert property (
    @(posedge clock) disable iff (!rst_n)
    ins_enable |-> (dispatch_enable &&
                    ({3'd0, iq_free_count} >= iq_watermark) &&
                    ({3'd0, new_count} + 5'd1 <= iq_free_count))
  );

endmodule

// File: source/rob_allocator.sv
`timescale 1ns/1ps
`include "dispatch_config.svh"

module rob_allocator (
  input  logic                       clock,
  input  logic                       rst_n,

  input  logic                       reserve,
  input  logic [1:0]                 reserve_count,
  input  logic [2:0]                 retire_count,

  output logic [`ROB_DEPTH_LOG2-1:0] reserved_slots [`DISPATCH_LANES],
  output logic [4:0]                 rob_free_count
);

  localparam int         SLOT_W    = `ROB_DEPTH_LOG2;
  localparam logic [4:0] ROB_SLOTS = 5'(`ROB_DEPTH);

  logic [SLOT_W-1:0] tail;
  logic [2:0]        take;

  // Slots offered to the next bundle, consecutive from the tail.
  for (genvar k = 0; k < `DISPATCH_LANES; k++) begin : g_slot
    assign reserved_slots[k] = tail + SLOT_W'(k);
  end

  assign take = reserve ? ({1'b0, reserve_count} + 3'd1) : 3'd0;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      tail           <= '0;
      rob_free_count <= ROB_SLOTS;
    end else begin
      tail           <= tail + SLOT_W'(take);
      rob_free_count <= rob_free_count - {2'd0, take} + {2'd0, retire_count};
    end
  end

  // ********************************************************************
  // Checks.
  // ********************************************************************

  a_no_over_reserve: assert property (
    @(posedge clock) disable iff (!rst_n)
    reserve |-> ({3'd0, reserve_count} + 5'd1 <= rob_free_count)
  );

  // Retire may only free slots that are currently held.
  a_no_over_retire: assert property (
    @(posedge clock) disable iff (!rst_n)
    {2'd0, retire_count} <= (ROB_SLOTS - rob_free_count)
  );

endmodule

// File: source/issue_queue.sv
`timescale 1ns/1ps
`include "dispatch_config.svh"

module issue_queue #(
  parameter type entry_type = dispatch_pkg::iq_entry_t
) (
  input  logic       clock,
  input  logic       rst_n,

  input  logic       ins_enable,
  input  logic [1:0] new_count,
  input  entry_type  new_elements [`DISPATCH_LANES],

  input  logic       issue_ready,
  output logic       issue_valid,
  output entry_type  issue_entry,

  output logic [4:0] iq_free_count
);

  localparam int         PTR_W = $clog2(`IQ_DEPTH);
  localparam logic [4:0] DEPTH = 5'(`IQ_DEPTH);

  entry_type        mem [`IQ_DEPTH];
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [4:0]       count;
  logic [2:0]       push_num;
  logic             pop;

  assign push_num = ins_enable ? ({1'b0, new_count} + 3'd1) : 3'd0;
  assign pop      = issue_valid && issue_ready;

  assign issue_valid   = (count != 5'd0);
  assign issue_entry   = mem[head];
  assign iq_free_count = DEPTH - count;

  // Storage. Entries beyond the pushed count are left alone.
  always_ff @(posedge clock) begin
    for (int k = 0; k < `DISPATCH_LANES; k++) begin
      if (3'(k) < push_num) begin
        mem[tail + PTR_W'(k)] <= new_elements[k];
      end
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= 5'd0;
    end else begin
      tail  <= tail + PTR_W'(push_num);
      head  <= head + PTR_W'(pop);
      count <= count + {2'd0, push_num} - {4'd0, pop};
    end
  end

  // A write may never exceed the room left after this cycle's pop is ignored.
  a_no_overflow: assert property (
    @(posedge clock) disable iff (!rst_n)
    ins_enable |-> ({3'd0, new_count} + 5'd1 <= iq_free_count)
  );

endmodule

// File: source/dispatch_regs.sv
`timescale 1ns/1ps
`include "dispatch_config.svh"

module dispatch_regs (
  input  logic       clock,
  input  logic       rst_n,

  input  logic       cfg_req,
  input  logic       cfg_write,
  input  logic       cfg_addr,
  input  logic [7:0] cfg_wdata,
  output logic       cfg_ack,
  output logic [7:0] cfg_rdata,

  output logic       dispatch_enable,
  output logic [7:0] iq_watermark
);

  localparam logic [7:0] WM_MIN = 8'(`DISPATCH_LANES);
  localparam logic [7:0] WM_MAX = 8'(`IQ_DEPTH);

  logic       accept;
  logic [7:0] wm_clamped;
  logic [7:0] rd_value;

  assign accept = cfg_req && !cfg_ack;

  always_comb begin
    if (cfg_wdata < WM_MIN) begin
      wm_clamped = WM_MIN;
    end else if (cfg_wdata > WM_MAX) begin
      wm_clamped = WM_MAX;
    end else begin
      wm_clamped = cfg_wdata;
    end
  end

  // A write reads back the value it leaves behind.
  always_comb begin
    rd_value = iq_watermark;
    case (cfg_addr)
      `CFG_ADDR_ENABLE:    rd_value = cfg_write ? {7'd0, cfg_wdata[0]} : {7'd0, dispatch_enable};
      `CFG_ADDR_WATERMARK: rd_value = cfg_write ? wm_clamped : iq_watermark;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      cfg_ack         <= 1'b0;
      dispatch_enable <= 1'b1;
      iq_watermark    <= `WATERMARK_RESET;
    end else if (accept) begin
      cfg_ack <= 1'b1;
      if (cfg_write && (cfg_addr == `CFG_ADDR_ENABLE)) begin
        dispatch_enable <= cfg_wdata[0];
      end
      if (cfg_write && (cfg_addr == `CFG_ADDR_WATERMARK)) begin
        iq_watermark <= wm_clamped;
      end
    end else if (!cfg_req) begin
      cfg_ack <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      cfg_rdata <= rd_value;
    end
  end

endmodule

// File: source/dispatch_unit.sv
`timescale 1ns/1ps
`include "dispatch_config.svh"

module dispatch_unit (
  input  logic                       clock,
  input  logic                       rst_n,

  input  logic [31:0]                fetch_word [`DISPATCH_LANES],
  input  logic [31:0]                fetch_pc [`DISPATCH_LANES],
  input  logic                       fetch_valid [`DISPATCH_LANES],
  input  logic                       fetch_req,
  output logic                       fetch_ack,

  input  logic                       cfg_req,
  input  logic                       cfg_write,
  input  logic                       cfg_addr,
  input  logic [7:0]                 cfg_wdata,
  output logic                       cfg_ack,
  output logic [7:0]                 cfg_rdata,

  output logic                       issue_valid,
  input  logic                       issue_ready,
  output logic [`ROB_DEPTH_LOG2-1:0] issue_rob_slot,
  output logic [31:0]                issue_pc,
  output dispatch_pkg::op_class_t    issue_op_class,
  output logic [4:0]                 issue_dest_reg,
  output logic                       issue_dest_reg_valid,
  output logic [4:0]                 issue_src1_reg,
  output logic                       issue_src1_valid,
  output logic [4:0]                 issue_src2_reg,
  output logic                       issue_src2_valid,

  input  logic [2:0]                 retire_count
);

  import dispatch_pkg::*;

  logic                       lane_valid [`DISPATCH_LANES];
  logic                       stall;
  logic                       fetch_accept;
  logic                       dispatch_enable;
  logic [7:0]                 iq_watermark;
  logic                       reserve;
  logic [1:0]                 reserve_count;
  logic [`ROB_DEPTH_LOG2-1:0] reserved_slots [`DISPATCH_LANES];
  logic [4:0]                 rob_free_count;
  logic                       ins_enable;
  logic [1:0]                 new_count;
  iq_entry_t                  new_elements [`DISPATCH_LANES];
  logic [4:0]                 iq_free_count;
  iq_entry_t                  issue_entry;

  // ********************************************************************
  // Fetch handshake.
  // ********************************************************************

  // Lanes are only presented while a bundle is pending and not yet taken.
  for (genvar i = 0; i < `DISPATCH_LANES; i++) begin : g_lane
    assign lane_valid[i] = fetch_valid[i] && fetch_req && !fetch_ack;
  end

  assign fetch_accept = fetch_req && !fetch_ack && !stall;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      fetch_ack <= 1'b0;
    end else if (fetch_accept) begin
      fetch_ack <= 1'b1;
    end else if (!fetch_req) begin
      fetch_ack <= 1'b0;
    end
  end

  decode_dispatch u_decode_dispatch (
    .clock           (clock),
    .rst_n           (rst_n),
    .inst_word       (fetch_word),
    .inst_pc         (fetch_pc),
    .inst_word_valid (lane_valid),
    .dispatch_enable (dispatch_enable),
    .iq_watermark    (iq_watermark),
    .rob_free_count  (rob_free_count),
    .iq_free_count   (iq_free_count),
    .reserved_slots  (reserved_slots),
    .stall           (stall),
    .reserve         (reserve),
    .reserve_count   (reserve_count),
    .ins_enable      (ins_enable),
    .new_count       (new_count),
    .new_elements    (new_elements)
  );

  rob_allocator u_rob_allocator (
    .clock          (clock),
    .rst_n          (rst_n),
    .reserve        (reserve),
    .reserve_count  (reserve_count),
    .retire_count   (retire_count),
    .reserved_slots (reserved_slots),
    .rob_free_count (rob_free_count)
  );

  issue_queue #(
    .entry_type (iq_entry_t)
  ) u_issue_queue (
    .clock         (clock),
    .rst_n         (rst_n),
    .ins_enable    (ins_enable),
    .new_count     (new_count),
    .new_elements  (new_elements),
    .issue_ready   (issue_ready),
    .issue_valid   (issue_valid),
    .issue_entry   (issue_entry),
    .iq_free_count (iq_free_count)
  );

  dispatch_regs u_dispatch_regs (
    .clock           (clock),
    .rst_n           (rst_n),
    .cfg_req         (cfg_req),
    .cfg_write       (cfg_write),
    .cfg_addr        (cfg_addr),
    .cfg_wdata       (cfg_wdata),
    .cfg_ack         (cfg_ack),
    .cfg_rdata       (cfg_rdata),
    .dispatch_enable (dispatch_enable),
    .iq_watermark    (iq_watermark)
  );

  // Head entry fields.
  assign issue_rob_slot       = issue_entry.rob_slot;
  assign issue_pc             = issue_entry.dec_inst.pc;
  assign issue_op_class       = issue_entry.dec_inst.op_class;
  assign issue_dest_reg       = issue_entry.dec_inst.dest_reg;
  assign issue_dest_reg_valid = issue_entry.dec_inst.dest_reg_valid;
  assign issue_src1_reg       = issue_entry.dec_inst.src1_reg;
  assign issue_src1_valid     = issue_entry.dec_inst.src1_valid;
  assign issue_src2_reg       = issue_entry.dec_inst.src2_reg;
  assign issue_src2_valid     = issue_entry.dec_inst.src2_valid;

endmodule

// File: sim/tb_dispatch_unit.sv
`timescale 1ns/1ps
`include "dispatch_config.svh"

module tb_dispatch_unit;

  localparam logic [3:0] C_ALU = 4'd0, C_ALU_IMM = 4'd1, C_LOAD = 4'd2, C_STORE = 4'd3;
  localparam logic [3:0] C_BRANCH = 4'd4, C_JAL = 4'd5, C_JALR = 4'd6, C_LUI = 4'd7;
  localparam logic [3:0] C_AUIPC = 4'd8, C_ILLEGAL = 4'd9;

  logic        clock = 1'b0;
  logic        rst_n = 1'b0;
  logic [31:0] fetch_word [`DISPATCH_LANES];
  logic [31:0] fetch_pc [`DISPATCH_LANES];
  logic        fetch_valid [`DISPATCH_LANES];
  logic        fetch_req, fetch_ack;
  logic        cfg_req, cfg_write, cfg_addr, cfg_ack;
  logic [7:0]  cfg_wdata, cfg_rdata;
  logic        issue_valid;
  logic        issue_ready = 1'b0;
  logic [3:0]  issue_rob_slot;
  logic [31:0] issue_pc;
  dispatch_pkg::op_class_t issue_op_class;
  logic [4:0]  issue_dest_reg, issue_src1_reg, issue_src2_reg;
  logic        issue_dest_reg_valid, issue_src1_valid, issue_src2_valid;
  logic [2:0]  retire_count;

  // Expected entries packed as slot, pc, class, rd, rd valid, rs1, valid, rs2, valid.
  logic [57:0] exp_q [$];
  logic [3:0]  next_slot = 4'd0;
  int          hold_cycles = 0;
  int          pop_count = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  dispatch_unit u_dut (.*);

  always #5 clock = ~clock;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping on first error");
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      fail_run("A DUT output differs from its expected value.");
    end
  endtask

  function automatic logic [57:0] model_entry(input logic [31:0] w, input logic [31:0] pc,
                                              input logic [3:0] slot);
    logic [3:0] op;
    logic       rdv;
    logic       s1v;
    logic       s2v;
    case (w[6:0])
      7'h33:   op = C_ALU;
      7'h13:   op = C_ALU_IMM;
      7'h03:   op = C_LOAD;
      7'h23:   op = C_STORE;
      7'h63:   op = C_BRANCH;
      7'h6f:   op = C_JAL;
      7'h67:   op = C_JALR;
      7'h37:   op = C_LUI;
      7'h17:   op = C_AUIPC;
      default: op = C_ILLEGAL;
    endcase
    rdv = (op != C_STORE) && (op != C_BRANCH) && (op != C_ILLEGAL) && (w[11:7] != 5'd0);
    s1v = (op == C_ALU) || (op == C_ALU_IMM) || (op == C_LOAD) || (op == C_STORE) ||
          (op == C_BRANCH) || (op == C_JALR);
    s2v = (op == C_ALU) || (op == C_STORE) || (op == C_BRANCH);
    return {slot, pc, op, w[11:7], rdv, w[19:15], s1v, w[24:20], s2v};
  endfunction

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      fail_run("Timeout: the run took more cycles than the stimulus allows.");
    end
  end

  // ********************************************************************
  // Issue consumer and checker.
  // ********************************************************************

  always @(negedge clock) begin
    logic [57:0] e;
    if (!rst_n) begin
      issue_ready = 1'b0;
    end else begin
      if (hold_cycles > 0) begin
        issue_ready = 1'b0;
        hold_cycles = hold_cycles - 1;
      end else begin
        issue_ready = ($urandom % 4) != 0;
      end
      if (issue_valid && issue_ready) begin
        if (exp_q.size() == 0) begin
          fail_run("An entry issued when none was expected.");
        end else begin
          e = exp_q.pop_front();
          pop_count = pop_count + 1;
          compare("issue_rob_slot", 32'(e[57:54]), 32'(issue_rob_slot));
          compare("issue_pc", e[53:22], issue_pc);
          compare("issue_op_class", 32'(e[21:18]), 32'(issue_op_class));
          compare("issue_dest_reg", 32'(e[17:13]), 32'(issue_dest_reg));
          compare("issue_dest_reg_valid", 32'(e[12]), 32'(issue_dest_reg_valid));
          compare("issue_src1_reg", 32'(e[11:7]), 32'(issue_src1_reg));
          compare("issue_src1_valid", 32'(e[6]), 32'(issue_src1_valid));
          compare("issue_src2_reg", 32'(e[5:1]), 32'(issue_src2_reg));
          compare("issue_src2_valid", 32'(e[0]), 32'(issue_src2_valid));
        end
      end
    end
  end

  // Raise req with the bundle and queue its expected entries in lane order.
  task automatic present_bundle(input logic [3:0] mask, input logic [31:0] w [4],
                                input logic [31:0] pc);
    @(negedge clock);
    for (int i = 0; i < `DISPATCH_LANES; i++) begin
      fetch_word[i]  = w[i];
      fetch_pc[i]    = pc + 32'(4 * i);
      fetch_valid[i] = mask[i];
      if (mask[i]) begin
        exp_q.push_back(model_entry(w[i], pc + 32'(4 * i), next_slot));
        next_slot = next_slot + 4'd1;
      end
    end
    fetch_req = 1'b1;
  endtask

  task automatic complete_bundle();
    do @(negedge clock); while (!fetch_ack);
    fetch_req = 1'b0;
    do @(negedge clock); while (fetch_ack);
  endtask

  task automatic cfg_access(input logic wr, input logic addr, input logic [7:0] wdata,
                            input logic [7:0] exp);
    @(negedge clock);
    cfg_write = wr;
    cfg_addr  = addr;
    cfg_wdata = wdata;
    cfg_req   = 1'b1;
    do @(negedge clock); while (!cfg_ack);
    compare("cfg_rdata", 32'(exp), 32'(cfg_rdata));
    cfg_req = 1'b0;
    do @(negedge clock); while (cfg_ack);
  endtask

  initial begin
    int          fd;
    int          records;
    int          start_pops;
    string       line;
    logic [31:0] a, b, c, d;
    logic [31:0] w [4];
    logic [31:0] pc;
    fetch_req    = 1'b0;
    cfg_req      = 1'b0;
    cfg_write    = 1'b0;
    cfg_addr     = 1'b0;
    cfg_wdata    = 8'd0;
    retire_count = 3'd0;
    for (int i = 0; i < `DISPATCH_LANES; i++) begin
      fetch_word[i]  = 32'd0;
      fetch_pc[i]    = 32'd0;
      fetch_valid[i] = 1'b0;
    end
    void'($urandom(85));
    fd = $fopen("sim/dispatch_input.txt", "r");
    if (fd == 0) begin
      fail_run("Could not open the stimulus file sim/dispatch_input.txt.");
    end
    records = 0;
    while ($fgets(line, fd) > 0) begin
      if (line.len() > 1 && line.getc(0) != "#") records = records + 1;
    end
    $fclose(fd);
    cycle_limit = 50 * records;
    fd = $fopen("sim/dispatch_input.txt", "r");

    repeat (16) @(negedge clock);
    rst_n = 1'b1;

    while ($fgets(line, fd) > 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin
        void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h %h %h",
                      a, b, c, d, w[0], w[1], w[2], w[3]));
        case (line.getc(0))
          "C": cfg_access(a[0], b[0], c[7:0], d[7:0]);
          "B": begin
            pc = w[1];
            w  = '{b, c, d, w[0]};
            present_bundle(a[3:0], w, pc);
            complete_bundle();
          end
          "S": begin
            // Cycles, no-pop flag, mask, four words, base PC.
            pc = w[3];
            w  = '{d, w[0], w[1], w[2]};
            present_bundle(c[3:0], w, pc);
            start_pops = pop_count;
            repeat (a) begin
              @(negedge clock);
              assert (!fetch_ack) else fail_run("A bundle was taken while dispatch should stall.");
            end
            if (b[0]) begin
              assert (pop_count == start_pops)
                else fail_run("An entry issued while the queue should be held.");
            end
          end
          "W": complete_bundle();
          "P": hold_cycles = a;
          "R": begin
            @(negedge clock);
            retire_count = a[2:0];
            @(negedge clock);
            retire_count = 3'd0;
          end
          "D": while (exp_q.size() != 0) @(negedge clock);
          default: fail_run("The stimulus file holds an unknown record type.");
        endcase
      end
    end
    $fclose(fd);
    repeat (4) @(negedge clock);
    if (exp_q.size() == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      fail_run("Some expected entries never issued.");
    end
  end

endmodule

// File: sim/dispatch_input.txt
# C wr addr wdata rdata | B mask w0 w1 w2 w3 pc | S cycles nopop mask w0 w1 w2 w3 pc
# W wait ack | P ready-low cycles | R retire count | D drain queue   (values in hex)
C 0 0 00 01
C 0 1 00 04
C 1 1 20 10
C 1 1 01 04
C 1 1 06 06
C 0 1 00 06
C 1 1 04 04
B F 007302B3 00508013 00012503 00322423 00001000
B F 00208063 000000EF 00008067 123453B7 00001010
B 3 00001497 FFFFFFFF 0000000B 00000000 00001020
R 4
B A 00508093 00000000 007302B3 00000000 00001030
B 4 00000000 00000000 00012503 00000000 00001040
B 0 007302B3 007302B3 007302B3 007302B3 00001050
B 9 000000EF 00000000 00000000 00322423 00001060
R 4
R 4
B F 007302B3 00508013 00012503 00322423 00001070
B F 00208063 000000EF 00008067 123453B7 00001080
R 4
B F 00001497 FFFFFFFF 00508093 00000000 00001090
R 4
B 5 007302B3 00000000 00008067 00000000 000010A0
R 4
B F 123453B7 00001497 00322423 00208063 000010B0
R 4
R 4
R 1
D
P 28
B F 007302B3 00508013 00012503 00322423 000010C0
B F 00208063 000000EF 00008067 123453B7 000010D0
B F 00001497 FFFFFFFF 0000000B 00508093 000010E0
B F 007302B3 00012503 00322423 00208063 000010F0
S 0A 1 F 000000EF 00008067 123453B7 00001497 00001100
R 4
R 4
R 4
R 4
W
D
R 4
B F 007302B3 00508013 00012503 00322423 00001110
B F 00208063 000000EF 00008067 123453B7 00001120
B F 00001497 FFFFFFFF 0000000B 00508093 00001130
B F 007302B3 00012503 00322423 00208063 00001140
S 08 0 1 00008067 00000000 00000000 00000000 00001150
R 1
W
R 4
R 4
R 4
R 4
D
P 28
B F 007302B3 00508013 00012503 00322423 00001160
C 1 1 10 10
S 06 1 1 123453B7 00000000 00000000 00000000 00001170
C 1 1 04 04
W
D
C 1 0 00 00
C 0 0 00 00
S 08 1 F 007302B3 00012503 00322423 00208063 00001180
C 1 0 01 01
W
D

// File: files.f
+incdir+source
source/dispatch_pkg.sv
source/inst_decoder.sv
source/decode_dispatch.sv
source/rob_allocator.sv
source/issue_queue.sv
source/dispatch_regs.sv
source/dispatch_unit.sv
sim/tb_dispatch_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the dispatch front testbench with Verilator.
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert \
    -f files.f \
    --top-module tb_dispatch_unit \
    --Mdir obj_dir -o tb_dispatch_unit &&
  ./obj_dir/tb_dispatch_unit ||
  { echo "simulation failed"; exit 1; }
